/* bridge_consts.svh */
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

// Bus widths
`define ADDR_W 32
`define DATA_W 64
`define STRB_W 8
`define ID_W   4

// AHB transfer types
`define HTRANS_IDLE   2'b00
`define HTRANS_NONSEQ 2'b10

// AXI response codes
`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10

// Fixed upper HPROT bits
`define HPROT_BASE 3'b001

`endif

/* bridge_pkg.sv */
`include "bridge_consts.svh"

package bridge_pkg;

   // AXI address command, shared by AW and AR
   typedef struct packed {
      logic [`ID_W-1:0]   id;
      logic [`ADDR_W-1:0] addr;
      logic [2:0]         size;
      logic [2:0]         prot;
   } aw_req_t;

   typedef struct packed {
      logic [`DATA_W-1:0] data;
      logic [`STRB_W-1:0] strb;
   } w_beat_t;

   // One AHB transfer within a doubleword
   typedef struct packed {
      logic [2:0] lo_addr;
      logic [2:0] size;
   } ahb_beat_t;

   typedef struct packed {
      logic [`ADDR_W-1:0] haddr;
      logic [2:0]         hsize;
      logic               hwrite;
      logic [3:0]         hprot;
      logic [1:0]         htrans;
   } ahb_req_t;

   typedef struct packed {
      logic [`ID_W-1:0]   id;
      logic               is_write;   // B channel when set, else R
      logic               error;
      logic [`DATA_W-1:0] rdata;
   } resp_t;

   typedef enum logic [1:0] {
      IDLE = 2'd0,
      ADDR = 2'd1,
      DATA = 2'd2,
      RESP = 2'd3
   } fsm_state_t;

endpackage

/* axi_hold_reg.sv */
`timescale 1ns/1ps

module axi_hold_reg #(
   parameter type payload_t = logic
) (
   input  logic     ahbm_clk,
   input  logic     rst,
   input  logic     valid_in,
   input  payload_t payload_in,
   input  logic     take,
   output logic     ready,
   output logic     valid,
   output payload_t payload
);

   logic load;

   assign load = valid_in & ready;

   // Ready mirrors an empty entry once out of reset
   always_ff @(posedge ahbm_clk) begin
      if (rst) begin
         valid <= 1'b0;
         ready <= 1'b0;
      end else if (take) begin
         valid <= 1'b0;
         ready <= 1'b1;   // Free again next cycle
      end else if (load) begin
         valid <= 1'b1;
         ready <= 1'b0;
      end else begin
         ready <= ~valid;
      end
   end

   always_ff @(posedge ahbm_clk) begin
      if (load) begin
         payload <= payload_in;
      end
   end

   // Only a held entry may be released by the FSM
   a_take_held: assert property (@(posedge ahbm_clk) disable iff (rst)
      take |-> valid);

endmodule

/* byte_lane_walker.sv */
`timescale 1ns/1ps
`include "bridge_consts.svh"

module byte_lane_walker
   import bridge_pkg::*;
(
   input  logic               ahbm_clk,
   input  logic               rst,
   input  logic               load,
   input  aw_req_t            cmd,
   input  logic [`STRB_W-1:0] strb,
   input  logic               advance,
   output ahb_beat_t          beat,
   output logic               last
);

   logic [`STRB_W-1:0] lanes;       // Byte lanes still to write
   logic               split;       // One byte beat per lane
   ahb_beat_t          single;
   ahb_beat_t          plan_beat;
   logic               aligned;

   function automatic logic [2:0] low_lane(input logic [`STRB_W-1:0] mask);
      logic [2:0] idx;
      idx = 3'd0;
      for (int i = `STRB_W - 1; i >= 0; i--) begin
         if (mask[i]) begin
            idx = 3'(i);
         end
      end
      return idx;
   endfunction

   // Beat plan for the incoming write
   always_comb begin
      aligned           = 1'b1;
      plan_beat.lo_addr = low_lane(strb);
      plan_beat.size    = 3'd0;
      if (cmd.size < 3'd3) begin
         plan_beat.lo_addr = cmd.addr[2:0];   // Narrow write goes as is
         plan_beat.size    = cmd.size;
      end else begin
         case (strb)
            8'hff:                      plan_beat.size = 3'd3;
            8'h0f, 8'hf0:               plan_beat.size = 3'd2;
            8'h03, 8'h0c, 8'h30, 8'hc0: plan_beat.size = 3'd1;
            default:                    aligned = $onehot(strb);
         endcase
      end
   end

   always_ff @(posedge ahbm_clk) begin
      if (rst) begin
         split <= 1'b0;
         lanes <= '0;
      end else if (load) begin
         split <= ~aligned;
         lanes <= strb;
      end else if (advance) begin
         lanes <= lanes & (lanes - 1'b1);   // Clear lowest lane
      end
   end

   always_ff @(posedge ahbm_clk) begin
      if (load) begin
         single <= plan_beat;
      end
   end

   assign beat.lo_addr = split ? low_lane(lanes) : single.lo_addr;
   assign beat.size    = split ? 3'd0 : single.size;
   assign last         = ~split | ((lanes & (lanes - 1'b1)) == '0);

   // A full-width write must enable at least one byte
   a_strb_nonzero: assert property (@(posedge ahbm_clk) disable iff (rst)
      (load && cmd.size == 3'd3) |-> (strb != '0));

endmodule

/* ahb_master_fsm.sv */
`timescale 1ns/1ps
`include "bridge_consts.svh"

module ahb_master_fsm
   import bridge_pkg::*;
(
   input  logic               ahbm_clk,
   input  logic               rst,
   input  aw_req_t            aw,
   input  logic               aw_valid,
   input  w_beat_t            w,
   input  logic               w_valid,
   input  aw_req_t            ar,
   input  logic               ar_valid,
   input  logic               resp_full,
   input  ahb_beat_t          beat,
   input  logic               last,
   input  logic [`DATA_W-1:0] hrdata,
   input  logic               hready,
   input  logic               hresp,
   output logic               take_w,
   output logic               ar_ready,
   output logic               walk_load,
   output logic               walk_advance,
   output ahb_req_t           ahb,
   output logic [`DATA_W-1:0] hwdata,
   output logic               resp_push,
   output resp_t              resp
);

   fsm_state_t         state;
   fsm_state_t         state_nxt;
   aw_req_t            cmd;
   logic               is_write;
   logic               error;
   logic               armed;       // Low until reset is released
   logic               wr_full;
   logic               accept_rd;
   logic               data_done;
   logic [`DATA_W-1:0] rdata_q;

   // ******************************
   // Arbitration
   // ******************************
   assign wr_full      = aw_valid & w_valid;   // Both write halves held
   assign walk_load    = (state == IDLE) & armed & wr_full & ~resp_full;
   assign ar_ready     = (state == IDLE) & armed & ~wr_full & ~resp_full;
   assign accept_rd    = ar_ready & ar_valid;
   assign data_done    = (state == DATA) & hready;
   assign walk_advance = data_done & is_write & ~hresp;
   assign take_w       = (state == RESP) & is_write;   // Hold regs kept until done

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (walk_load | accept_rd) begin
               state_nxt = ADDR;
            end
         end
         ADDR: begin
            if (hready) begin
               state_nxt = DATA;
            end
         end
         DATA: begin
            if (hready) begin
               state_nxt = (is_write & ~last & ~hresp) ? ADDR : RESP;
            end
         end
         default: state_nxt = IDLE;   // RESP lasts one cycle
      endcase
   end

   always_ff @(posedge ahbm_clk) begin
      if (rst) begin
         state    <= IDLE;
         armed    <= 1'b0;
         is_write <= 1'b0;
         error    <= 1'b0;
      end else begin
         state <= state_nxt;
         armed <= 1'b1;
         if (walk_load | accept_rd) begin
            is_write <= walk_load;
            error    <= 1'b0;
         end else if (data_done & hresp) begin
            error <= 1'b1;   // Ends the command
         end
      end
   end

   always_ff @(posedge ahbm_clk) begin
      if (walk_load) begin
         cmd <= aw;
      end else if (accept_rd) begin
         cmd <= ar;
      end
      if (data_done & ~is_write) begin
         rdata_q <= hrdata;
      end
   end

   // ******************************
   // AHB address and data phase
   // ******************************
   always_comb begin
      ahb.htrans = (state == ADDR) ? `HTRANS_NONSEQ : `HTRANS_IDLE;
      ahb.hwrite = is_write;
      ahb.hprot  = {`HPROT_BASE, ~cmd.prot[2]};
      ahb.haddr  = {cmd.addr[`ADDR_W-1:3], is_write ? beat.lo_addr : cmd.addr[2:0]};
      ahb.hsize  = is_write ? beat.size : cmd.size;
   end

   assign hwdata = w.data;

   assign resp_push     = (state == RESP);
   assign resp.id       = cmd.id;
   assign resp.is_write = is_write;
   assign resp.error    = error;
   assign resp.rdata    = (is_write | error) ? '0 : rdata_q;

   // Walker beats and read commands must be size aligned
   a_haddr_aligned: assert property (@(posedge ahbm_clk) disable iff (rst)
      (ahb.htrans == `HTRANS_NONSEQ) |->
         ((ahb.haddr[2:0] & ~(3'h7 << ahb.hsize)) == 3'd0));

   a_addr_hold: assert property (@(posedge ahbm_clk) disable iff (rst)
      (state == ADDR && !hready) |=> (state == ADDR && $stable(ahb)));

endmodule

/* axi_resp_buf.sv */
`timescale 1ns/1ps

module axi_resp_buf
   import bridge_pkg::*;
(
   input  logic  ahbm_clk,
   input  logic  rst,
   input  logic  push,
   input  resp_t resp_in,
   input  logic  bready,
   input  logic  rready,
   output logic  full,
   output logic  bvalid,
   output logic  rvalid,
   output resp_t resp
);

   logic valid;
   logic done;

   assign bvalid = valid & resp.is_write;
   assign rvalid = valid & ~resp.is_write;
   assign full   = valid;   // Blocks new commands
   assign done   = (bvalid & bready) | (rvalid & rready);

   always_ff @(posedge ahbm_clk) begin
      if (rst) begin
         valid <= 1'b0;
      end else if (push) begin
         valid <= 1'b1;
      end else if (done) begin
         valid <= 1'b0;
      end
   end

   always_ff @(posedge ahbm_clk) begin
      if (push) begin
         resp <= resp_in;
      end
   end

   // FSM must wait for the master to drain the entry
   a_no_push_full: assert property (@(posedge ahbm_clk) disable iff (rst)
      push |-> !full);

endmodule

/* axi_ahb_bridge.sv */
`timescale 1ns/1ps
`include "bridge_consts.svh"

module axi_ahb_bridge
   import bridge_pkg::*;
(
   input  logic               ahbm_clk,
   input  logic               rst,
   // AXI write address
   input  logic               axi_awvalid,
   output logic               axi_awready,
   input  logic [`ID_W-1:0]   axi_awid,
   input  logic [`ADDR_W-1:0] axi_awaddr,
   input  logic [2:0]         axi_awsize,
   input  logic [2:0]         axi_awprot,
   // AXI write data
   input  logic               axi_wvalid,
   output logic               axi_wready,
   input  logic [`DATA_W-1:0] axi_wdata,
   input  logic [`STRB_W-1:0] axi_wstrb,
   // AXI write response
   output logic               axi_bvalid,
   input  logic               axi_bready,
   output logic [1:0]         axi_bresp,
   output logic [`ID_W-1:0]   axi_bid,
   // AXI read address
   input  logic               axi_arvalid,
   output logic               axi_arready,
   input  logic [`ID_W-1:0]   axi_arid,
   input  logic [`ADDR_W-1:0] axi_araddr,
   input  logic [2:0]         axi_arsize,
   input  logic [2:0]         axi_arprot,
   // AXI read data
   output logic               axi_rvalid,
   input  logic               axi_rready,
   output logic [`ID_W-1:0]   axi_rid,
   output logic [`DATA_W-1:0] axi_rdata,
   output logic [1:0]         axi_rresp,
   output logic               axi_rlast,
   // AHB-Lite master
   output logic [`ADDR_W-1:0] ahb_haddr,
   output logic [2:0]         ahb_hburst,
   output logic               ahb_hmastlock,
   output logic [3:0]         ahb_hprot,
   output logic [2:0]         ahb_hsize,
   output logic [1:0]         ahb_htrans,
   output logic               ahb_hwrite,
   output logic [`DATA_W-1:0] ahb_hwdata,
   input  logic [`DATA_W-1:0] ahb_hrdata,
   input  logic               ahb_hready,
   input  logic               ahb_hresp
);

   aw_req_t   aw_in;
   aw_req_t   aw_q;
   aw_req_t   ar_in;
   w_beat_t   w_in;
   w_beat_t   w_q;
   logic      aw_q_valid;
   logic      w_q_valid;
   logic      take_w;
   logic      walk_load;
   logic      walk_advance;
   logic      last;
   ahb_beat_t beat;
   ahb_req_t  ahb;
   logic      resp_full;
   logic      resp_push;
   resp_t     resp_new;
   resp_t     resp_out;
   logic [1:0] resp_code;

   // ******************************
   // Pin packing
   // ******************************
   assign aw_in = '{id: axi_awid, addr: axi_awaddr, size: axi_awsize, prot: axi_awprot};
   assign ar_in = '{id: axi_arid, addr: axi_araddr, size: axi_arsize, prot: axi_arprot};
   assign w_in  = '{data: axi_wdata, strb: axi_wstrb};

   axi_hold_reg #(.payload_t(aw_req_t)) aw_hold_i (
      .ahbm_clk(ahbm_clk), .rst(rst), .valid_in(axi_awvalid), .payload_in(aw_in),
      .take(take_w), .ready(axi_awready), .valid(aw_q_valid), .payload(aw_q)
   );

   axi_hold_reg #(.payload_t(w_beat_t)) w_hold_i (
      .ahbm_clk(ahbm_clk), .rst(rst), .valid_in(axi_wvalid), .payload_in(w_in),
      .take(take_w), .ready(axi_wready), .valid(w_q_valid), .payload(w_q)
   );

   byte_lane_walker walker_i (
      .ahbm_clk(ahbm_clk), .rst(rst), .load(walk_load), .cmd(aw_q), .strb(w_q.strb),
      .advance(walk_advance), .beat(beat), .last(last)
   );

   ahb_master_fsm fsm_i (
      .ahbm_clk(ahbm_clk), .rst(rst), .aw(aw_q), .aw_valid(aw_q_valid), .w(w_q),
      .w_valid(w_q_valid), .ar(ar_in), .ar_valid(axi_arvalid), .resp_full(resp_full),
      .beat(beat), .last(last), .hrdata(ahb_hrdata), .hready(ahb_hready), .hresp(ahb_hresp),
      .take_w(take_w), .ar_ready(axi_arready), .walk_load(walk_load),
      .walk_advance(walk_advance), .ahb(ahb), .hwdata(ahb_hwdata),
      .resp_push(resp_push), .resp(resp_new)
   );

   axi_resp_buf resp_buf_i (
      .ahbm_clk(ahbm_clk), .rst(rst), .push(resp_push), .resp_in(resp_new),
      .bready(axi_bready), .rready(axi_rready), .full(resp_full),
      .bvalid(axi_bvalid), .rvalid(axi_rvalid), .resp(resp_out)
   );

   // ******************************
   // Response and AHB pins
   // ******************************
   assign resp_code = resp_out.error ? `RESP_SLVERR : `RESP_OKAY;
   assign axi_bresp = resp_code;
   assign axi_bid   = resp_out.id;
   assign axi_rresp = resp_code;
   assign axi_rid   = resp_out.id;
   assign axi_rdata = resp_out.rdata;
   assign axi_rlast = 1'b1;   // Single beat reads only

   assign ahb_haddr     = ahb.haddr;
   assign ahb_hsize     = ahb.hsize;
   assign ahb_hwrite    = ahb.hwrite;
   assign ahb_hprot     = ahb.hprot;
   assign ahb_htrans    = ahb.htrans;
   assign ahb_hburst    = 3'b000;   // SINGLE
   assign ahb_hmastlock = 1'b0;

endmodule

/* tb_ahb_mem.sv */
`timescale 1ns/1ps
`include "bridge_consts.svh"

module tb_ahb_mem (
   input  logic               ahbm_clk,
   input  logic               rst,
   input  logic [`ADDR_W-1:0] haddr,
   input  logic [2:0]         hsize,
   input  logic [1:0]         htrans,
   input  logic               hwrite,
   input  logic [`DATA_W-1:0] hwdata,
   output logic [`DATA_W-1:0] hrdata,
   output logic               hready,
   output logic               hresp
);

   logic [`DATA_W-1:0] mem [8];
   logic [15:0]        lfsr;
   logic [15:0]        lfsr_1;
   logic [15:0]        lfsr_2;
   logic               busy;        // Data phase in progress
   logic               err;
   logic               err_first;
   logic [1:0]         wait_cnt;
   logic [5:0]         addr_q;
   logic [2:0]         size_q;
   logic               write_q;

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   assign lfsr_1 = lfsr_step(lfsr);
   assign lfsr_2 = lfsr_step(lfsr_1);

   always_comb begin
      hready = 1'b1;
      hresp  = 1'b0;
      if (busy && err) begin
         hready = ~err_first;   // Two-cycle error response
         hresp  = 1'b1;
      end else if (busy) begin
         hready = (wait_cnt == 2'd0);
      end
   end

   assign hrdata = (busy && !write_q && !err) ? mem[addr_q[5:3]] : '0;

   always_ff @(posedge ahbm_clk) begin
      if (rst) begin
         busy      <= 1'b0;
         err       <= 1'b0;
         err_first <= 1'b0;
         wait_cnt  <= 2'd0;
         lfsr      <= 16'd62;
         for (int i = 0; i < 8; i++) begin
            mem[i] <= {8{8'(8'h11 * i + 8'h0f)}};
         end
      end else if (busy) begin
         if (hready) begin
            busy <= 1'b0;
            if (write_q && !err) begin
               for (int i = 0; i < 8; i++) begin
                  if (i >= int'(addr_q[2:0]) && i < int'(addr_q[2:0]) + (1 << size_q)) begin
                     mem[addr_q[5:3]][8*i +: 8] <= hwdata[8*i +: 8];
                  end
               end
            end
         end else if (err) begin
            err_first <= 1'b0;
         end else begin
            wait_cnt <= wait_cnt - 2'd1;
         end
      end else if (htrans == `HTRANS_NONSEQ) begin
         busy      <= 1'b1;
         err       <= haddr[31];   // Upper half of the map faults
         err_first <= 1'b1;
         addr_q    <= haddr[5:0];
         size_q    <= hsize;
         write_q   <= hwrite;
         wait_cnt  <= {lfsr_1[0], lfsr_2[0]};
         lfsr      <= lfsr_2;
      end
   end

endmodule

/* tb_axi_ahb_bridge.sv */
`timescale 1ns/1ps
`include "bridge_consts.svh"

module tb_axi_ahb_bridge;

   localparam int WAIT_LIMIT = 100;   // Cycles per handshake

   logic               ahbm_clk = 1'b0;
   logic               rst;
   logic               axi_awvalid;
   logic               axi_awready;
   logic [`ID_W-1:0]   axi_awid;
   logic [`ADDR_W-1:0] axi_awaddr;
   logic [2:0]         axi_awsize;
   logic [2:0]         axi_awprot;
   logic               axi_wvalid;
   logic               axi_wready;
   logic [`DATA_W-1:0] axi_wdata;
   logic [`STRB_W-1:0] axi_wstrb;
   logic               axi_bvalid;
   logic               axi_bready;
   logic [1:0]         axi_bresp;
   logic [`ID_W-1:0]   axi_bid;
   logic               axi_arvalid;
   logic               axi_arready;
   logic [`ID_W-1:0]   axi_arid;
   logic [`ADDR_W-1:0] axi_araddr;
   logic [2:0]         axi_arsize;
   logic [2:0]         axi_arprot;
   logic               axi_rvalid;
   logic               axi_rready;
   logic [`ID_W-1:0]   axi_rid;
   logic [`DATA_W-1:0] axi_rdata;
   logic [1:0]         axi_rresp;
   logic               axi_rlast;
   logic [`ADDR_W-1:0] ahb_haddr;
   logic [2:0]         ahb_hburst;
   logic               ahb_hmastlock;
   logic [3:0]         ahb_hprot;
   logic [2:0]         ahb_hsize;
   logic [1:0]         ahb_htrans;
   logic               ahb_hwrite;
   logic [`DATA_W-1:0] ahb_hwdata;
   logic [`DATA_W-1:0] ahb_hrdata;
   logic               ahb_hready;
   logic               ahb_hresp;

   logic [`DATA_W-1:0] model [8];   // Reference memory
   logic [15:0]        lfsr_q = 16'd62;
   logic [3:0]         exp_hprot;   // HPROT of the command now in flight
   int                 checks;
   int                 errors;
   int                 tests;
   int                 failed_tests;
   int                 wr_beats;
   logic               timed_out;

   always #10 ahbm_clk = ~ahbm_clk;

   axi_ahb_bridge axi_ahb_bridge_i (.*);

   tb_ahb_mem mem_i (
      .ahbm_clk(ahbm_clk), .rst(rst), .haddr(ahb_haddr), .hsize(ahb_hsize),
      .htrans(ahb_htrans), .hwrite(ahb_hwrite), .hwdata(ahb_hwdata),
      .hrdata(ahb_hrdata), .hready(ahb_hready), .hresp(ahb_hresp)
   );

   // Address phases seen on the AHB pins
   always @(negedge ahbm_clk) begin
      if (ahb_htrans == `HTRANS_NONSEQ) begin
         if (ahb_hready && ahb_hwrite) begin
            wr_beats++;
         end
         check("ahb_ctrl", 64'(exp_hprot), 64'(ahb_hprot));
         check("ahb_ctrl", 64'd0, 64'({ahb_hburst, ahb_hmastlock}));   // SINGLE, unlocked
      end
   end

   // ******************************
   // Helpers
   // ******************************
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] draw(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v      = {v[30:0], lfsr_q[0]};   // One step per bit
      end
      return v;
   endfunction

   // Strobes the walker sends as one transfer
   function automatic logic is_single_beat(input logic [7:0] s);
      return (s inside {8'hff, 8'h0f, 8'hf0, 8'h03, 8'h0c, 8'h30, 8'hc0}) || $onehot(s);
   endfunction

   function automatic logic resp_valid(input logic is_wr);
      return is_wr ? axi_bvalid : axi_rvalid;
   endfunction

   task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("ERR %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic timeout_hit(input string what);
      $display("Timeout while waiting for %s", what);
      timed_out = 1'b1;
   endtask

   task automatic finish_test(input string name, input int errs_before);
      tests++;
      if (errors == errs_before) begin
         $display("test %s: ok", name);
      end else begin
         failed_tests++;
         $display("test %s: %0d mismatches", name, errors - errs_before);
      end
   endtask

   task automatic send_aw(input logic [3:0] id, input logic [31:0] addr, input logic [2:0] size);
      int t;
      axi_awid    = id;
      axi_awaddr  = addr;
      axi_awsize  = size;
      axi_awprot  = 3'(draw(3));
      exp_hprot   = {`HPROT_BASE, ~axi_awprot[2]};
      axi_awvalid = 1'b1;
      t = 0;
      while (!axi_awready && t < WAIT_LIMIT && !timed_out) begin
         @(negedge ahbm_clk);
         t++;
      end
      if (!axi_awready && !timed_out) begin
         timeout_hit("AWREADY");
      end
      @(negedge ahbm_clk);   // Handshake on the edge between
      axi_awvalid = 1'b0;
   endtask

   task automatic send_w(input logic [63:0] data, input logic [7:0] strb);
      int t;
      axi_wdata  = data;
      axi_wstrb  = strb;
      axi_wvalid = 1'b1;
      t = 0;
      while (!axi_wready && t < WAIT_LIMIT && !timed_out) begin
         @(negedge ahbm_clk);
         t++;
      end
      if (!axi_wready && !timed_out) begin
         timeout_hit("WREADY");
      end
      @(negedge ahbm_clk);
      axi_wvalid = 1'b0;
   endtask

   task automatic send_ar(input logic [3:0] id, input logic [31:0] addr, input logic [2:0] size);
      int t;
      axi_arid    = id;
      axi_araddr  = addr;
      axi_arsize  = size;
      axi_arprot  = 3'(draw(3));
      exp_hprot   = {`HPROT_BASE, ~axi_arprot[2]};
      axi_arvalid = 1'b1;
      t = 0;
      while (!axi_arready && t < WAIT_LIMIT && !timed_out) begin
         @(negedge ahbm_clk);
         t++;
      end
      if (!axi_arready && !timed_out) begin
         timeout_hit("ARREADY");
      end
      @(negedge ahbm_clk);
      axi_arvalid = 1'b0;
   endtask

   task automatic wait_valid(input logic is_wr);
      int t;
      t = 0;
      while (!resp_valid(is_wr) && t < WAIT_LIMIT && !timed_out) begin
         @(negedge ahbm_clk);
         t++;
      end
      if (!resp_valid(is_wr) && !timed_out) begin
         timeout_hit(is_wr ? "BVALID" : "RVALID");
      end
   endtask

   // Response held for hold cycles before the master takes it
   task automatic wait_resp(input string name, input logic is_wr, input logic [3:0] id,
                            input logic [1:0] code, input logic [63:0] data, input int hold);
      wait_valid(is_wr);
      if (timed_out) begin
         return;
      end
      for (int c = 0; c <= hold; c++) begin
         check(name, 64'd1, 64'(resp_valid(is_wr)));
         check(name, 64'(id), 64'(is_wr ? axi_bid : axi_rid));
         check(name, 64'(code), 64'(is_wr ? axi_bresp : axi_rresp));
         check(name, 64'(`HTRANS_IDLE), 64'(ahb_htrans));   // No transfer while held
         check(name, 64'd0, 64'(axi_arready));
         if (!is_wr) begin
            check(name, data, axi_rdata);
            check(name, 64'd1, 64'(axi_rlast));
         end
         if (c < hold) begin
            @(negedge ahbm_clk);
         end
      end
      axi_bready = is_wr;
      axi_rready = ~is_wr;
      @(negedge ahbm_clk);
      axi_bready = 1'b0;
      axi_rready = 1'b0;
      check(name, 64'd0, 64'(resp_valid(is_wr)));
   endtask

   // order 0 together, 1 AW first, 2 W first, 3 AW then a gap
   task automatic do_write(input string name, input logic [3:0] id, input logic [31:0] addr,
                           input logic [2:0] size, input logic [63:0] data,
                           input logic [7:0] strb, input int order, input int hold);
      logic [1:0] code;
      code = addr[31] ? `RESP_SLVERR : `RESP_OKAY;
      case (order)
         0: begin
            fork
               send_aw(id, addr, size);
               send_w(data, strb);
            join
         end
         1: begin
            send_aw(id, addr, size);
            send_w(data, strb);
         end
         2: begin
            send_w(data, strb);
            send_aw(id, addr, size);
         end
         default: begin
            send_aw(id, addr, size);
            repeat (3) @(negedge ahbm_clk);
            send_w(data, strb);
         end
      endcase
      if (!addr[31]) begin
         for (int i = 0; i < 8; i++) begin
            if (strb[i]) begin
               model[addr[5:3]][8*i +: 8] = data[8*i +: 8];
            end
         end
      end
      wait_resp(name, 1'b1, id, code, '0, hold);
   endtask

   task automatic do_read(input string name, input logic [3:0] id, input logic [31:0] addr,
                          input int hold);
      send_ar(id, addr, 3'd3);
      if (addr[31]) begin
         wait_resp(name, 1'b0, id, `RESP_SLVERR, '0, hold);   // Error data reads as zero
      end else begin
         wait_resp(name, 1'b0, id, `RESP_OKAY, model[addr[5:3]], hold);
      end
   endtask

   // ******************************
   // Tests
   // ******************************
   task automatic full_word_writes();
      int e0;
      e0 = errors;
      for (int i = 0; i < 8; i++) begin
         do_write("full_word", 4'(draw(4)), 32'(i * 8), 3'd3, {draw(32), draw(32)},
                  8'hff, 0, 0);
      end
      for (int i = 0; i < 8; i++) begin
         do_read("full_word", 4'(draw(4)), 32'(i * 8), 0);
      end
      finish_test("full_word", e0);
   endtask

   task automatic narrow_writes();
      int         e0;
      logic [2:0] sz;
      logic [2:0] lo;
      logic [2:0] idx;
      logic [7:0] strb;
      e0 = errors;
      for (int n = 0; n < 12; n++) begin
         sz = 3'(draw(2));
         if (sz == 3'd3) begin
            sz = 3'd2;
         end
         lo   = 3'(draw(3)) & ~((3'd1 << sz) - 3'd1);   // Aligned to size
         idx  = 3'(draw(3));
         strb = ((8'd1 << (4'd1 << sz)) - 8'd1) << lo;
         do_write("narrow", 4'(draw(4)), {26'd0, idx, lo}, sz, {draw(32), draw(32)},
                  strb, 0, 0);
         do_read("narrow", 4'(draw(4)), {26'd0, idx, 3'd0}, 0);
      end
      finish_test("narrow", e0);
   endtask

   task automatic split_strobes();
      int         e0;
      logic [2:0] idx;
      logic [7:0] strb;
      e0 = errors;
      for (int n = 0; n < 10; n++) begin
         idx  = 3'(draw(3));
         strb = 8'(draw(8));
         while (strb == 8'h00 || is_single_beat(strb)) begin
            strb = 8'(draw(8));
         end
         wr_beats = 0;
         do_write("split", 4'(draw(4)), {26'd0, idx, 3'd0}, 3'd3, {draw(32), draw(32)},
                  strb, 0, 0);
         check("split", 64'($countones(strb)), 64'(wr_beats));
         do_read("split", 4'(draw(4)), {26'd0, idx, 3'd0}, 0);
      end
      finish_test("split", e0);
   endtask

   task automatic error_region();
      int         e0;
      logic [2:0] idx;
      e0 = errors;
      for (int n = 0; n < 4; n++) begin
         idx      = 3'(draw(3));
         wr_beats = 0;
         do_write("error", 4'(draw(4)), {1'b1, 25'd0, idx, 3'd0}, 3'd3,
                  {draw(32), draw(32)}, 8'h5a, 0, 0);
         check("error", 64'd1, 64'(wr_beats));   // Split write stops at the fault
         do_read("error", 4'(draw(4)), {1'b1, 25'd0, idx, 3'd0}, 0);
      end
      for (int i = 0; i < 8; i++) begin
         do_read("error", 4'(draw(4)), 32'(i * 8), 0);
      end
      finish_test("error", e0);
   endtask

   task automatic response_stall();
      int          e0;
      logic [2:0]  idx;
      logic [3:0]  wid;
      logic [3:0]  rid;
      logic [31:0] addr;
      logic [63:0] data;
      int          hold_b;
      int          hold_r;
      e0 = errors;
      for (int n = 0; n < 4; n++) begin
         idx    = 3'(draw(3));
         wid    = 4'(draw(4));
         rid    = 4'(draw(4));
         addr   = {26'd0, idx, 3'd0};
         data   = {draw(32), draw(32)};
         hold_b = 2 + int'(draw(3));
         hold_r = 2 + int'(draw(3));
         // Read-back waits on AR while B is held
         fork
            do_write("stall", wid, addr, 3'd3, data, 8'hff, 0, hold_b);
            begin
               wait_valid(1'b1);
               send_ar(rid, addr, 3'd3);
            end
         join
         // Same write waits in the hold registers while R is held
         fork
            wait_resp("stall", 1'b0, rid, `RESP_OKAY, model[idx], hold_r);
            begin
               wait_valid(1'b0);
               do_write("stall", wid, addr, 3'd3, data, 8'hff, 0, 0);
            end
         join
      end
      finish_test("stall", e0);
   endtask

   task automatic channel_order();
      int         e0;
      logic [2:0] idx;
      e0 = errors;
      for (int n = 0; n < 8; n++) begin
         idx = 3'(draw(3));
         do_write("order", 4'(draw(4)), {26'd0, idx, 3'd0}, 3'd3, {draw(32), draw(32)},
                  8'hff, n % 4, 0);
         do_read("order", 4'(draw(4)), {26'd0, idx, 3'd0}, 0);
      end
      finish_test("order", e0);
   endtask

   initial begin
      int e0;
      checks       = 0;
      errors       = 0;
      tests        = 0;
      failed_tests = 0;
      wr_beats     = 0;
      timed_out    = 1'b0;
      exp_hprot    = '0;
      rst          = 1'b1;
      axi_awvalid  = 1'b0;
      axi_awid     = '0;
      axi_awaddr   = '0;
      axi_awsize   = '0;
      axi_awprot   = 3'b010;
      axi_wvalid   = 1'b0;
      axi_wdata    = '0;
      axi_wstrb    = '0;
      axi_bready   = 1'b0;
      axi_arvalid  = 1'b0;
      axi_arid     = '0;
      axi_araddr   = '0;
      axi_arsize   = '0;
      axi_arprot   = 3'b010;
      axi_rready   = 1'b0;

      e0 = errors;
      repeat (5) begin
         @(negedge ahbm_clk);
         check("reset", 64'd0,
               64'({axi_awready, axi_wready, axi_arready, axi_bvalid, axi_rvalid}));
         check("reset", 64'(`HTRANS_IDLE), 64'(ahb_htrans));
      end
      finish_test("reset", e0);
      rst = 1'b0;

      full_word_writes();
      narrow_writes();
      split_strobes();
      error_region();
      response_stall();
      channel_order();

      $display("%0d tests, %0d failed, %0d checks, %0d mismatches",
               tests, failed_tests, checks, errors);
      if (errors == 0 && !timed_out) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

/* filelist.f */
+incdir+.
bridge_pkg.sv
axi_hold_reg.sv
byte_lane_walker.sv
ahb_master_fsm.sv
axi_resp_buf.sv
axi_ahb_bridge.sv
tb_ahb_mem.sv
tb_axi_ahb_bridge.sv

/* Makefile */
TOP := tb_axi_ahb_bridge

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f -Mdir obj_dir

run: compile
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
